//--- Bender.yml
package:
  name: cgra_slice

sources:
  - common/cgra_cfg_pkg.sv
  - common/cgra_ctrl_pkg.sv
  - hw/cgra_wb_regs.sv
  - cgra/cgra_stream_in.sv
  - cgra/cgra_pe.sv
  - cgra/cgra_stream_out.sv
  - cgra/cgra_control_exec.sv
  - hw/cgra_top.sv
  - target: test
    files:
      - verification/cgra_props.sv
      - verification/cgra_tb.sv

//--- cgra/cgra_control_exec.sv
`timescale 1ns/1ps
`default_nettype none

module cgra_control_exec import cgra_cfg_pkg::*; import cgra_ctrl_pkg::*; #(
  parameter int N_LANES = n_lanes_def
) (
  input  wire                clk,
  input  wire                rst,
  input  wire                start,
  input  wire                clear,
  input  wire [N_LANES-1:0]  lane_mask,
  input  wire [N_LANES-1:0]  in_valid,
  input  wire [N_LANES-1:0]  out_room,
  input  wire [N_LANES-1:0]  lane_done,
  output logic [N_LANES-1:0] en,
  output exec_state_t        state
);

  logic [N_LANES-1:0] active;
  logic all_ready;
  logic all_done;

  assign active = lane_mask & ~lane_done;
  // masked-off or finished lanes never hold the others back
  assign all_ready = &(~active | (in_valid & out_room));
  assign all_done = &(~lane_mask | lane_done);

  // lockstep, one stalled lane stalls every lane
  assign en = (state == st_process && all_ready) ? active : '0;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= st_idle;
    end else if (clear) begin
      state <= st_idle;  // also aborts a run in progress
    end else begin
      case (state)
        st_idle: begin
          if (start) state <= st_wait_data;
        end
        st_wait_data: begin
          if (all_ready) state <= st_process;
        end
        st_process: begin
          if (all_done) state <= st_done;
        end
        st_done: begin
          state <= st_done;  // held until clear
        end
        default: state <= st_idle;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- cgra/cgra_pe.sv
`timescale 1ns/1ps
`default_nettype none

module cgra_pe import cgra_cfg_pkg::*; #(
  parameter int DATA_W = data_w_def
) (
  input  wire               clk,
  input  wire               rst,
  input  wire               clear,
  input  wire               en,
  input  wire pe_op_t       op,
  input  wire [DATA_W-1:0]  lane_const,
  input  wire [len_w-1:0]   length,
  input  wire [DATA_W-1:0]  in_data,
  output logic              out_push,
  output logic [DATA_W-1:0] out_data,
  output logic              lane_done
);

  logic [len_w-1:0] consumed;
  logic [DATA_W-1:0] result;

  always_comb begin
    case (op)
      op_add:  result = in_data + lane_const;
      op_sub:  result = in_data - lane_const;
      op_xor:  result = in_data ^ lane_const;
      default: result = in_data;  // op_pass
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      out_push <= 1'b0;
      consumed <= '0;
    end else begin
      out_push <= en;  // result lands in the out fifo one edge later
      if (clear) consumed <= '0;
      else if (en) consumed <= consumed + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (en) out_data <= result;
  end

  assign lane_done = consumed >= length;

endmodule

`default_nettype wire

//--- cgra/cgra_stream_in.sv
`timescale 1ns/1ps
`default_nettype none

module cgra_stream_in import cgra_cfg_pkg::*; #(
  parameter int N_LANES = n_lanes_def,
  parameter int DATA_W = data_w_def,
  parameter int FIFO_DEPTH = fifo_depth_def
) (
  input  wire                       clk,
  input  wire                       rst,
  input  wire                       clear,
  input  wire [N_LANES-1:0]         push,
  input  wire [DATA_W-1:0]          push_data,
  input  wire [N_LANES-1:0]         pop,
  output logic [N_LANES-1:0]        in_valid,
  output logic [N_LANES*DATA_W-1:0] in_data_flat,
  output logic [N_LANES-1:0]        in_full
);

  localparam int ptr_w = $clog2(FIFO_DEPTH);
  localparam int cnt_w = $clog2(FIFO_DEPTH + 1);

  for (genvar l = 0; l < N_LANES; l++) begin : g_lane
    logic [DATA_W-1:0] mem [FIFO_DEPTH];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;
    logic do_push;
    logic do_pop;

    assign do_push = push[l] && !in_full[l];
    assign do_pop = pop[l] && in_valid[l];
    assign in_valid[l] = count != '0;
    assign in_full[l] = count == cnt_w'(FIFO_DEPTH);
    assign in_data_flat[l*DATA_W +: DATA_W] = mem[rd_ptr];  // head word, popped on en

    always_ff @(posedge clk) begin
      if (rst || clear) begin
        wr_ptr <= '0;
        rd_ptr <= '0;
        count <= '0;
      end else begin
        if (do_push) wr_ptr <= (wr_ptr == ptr_w'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
        if (do_pop) rd_ptr <= (rd_ptr == ptr_w'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
        count <= count + cnt_w'(do_push) - cnt_w'(do_pop);
      end
    end

    always_ff @(posedge clk) begin
      if (do_push) mem[wr_ptr] <= push_data;
    end
  end

endmodule

`default_nettype wire

//--- cgra/cgra_stream_out.sv
`timescale 1ns/1ps
`default_nettype none

module cgra_stream_out import cgra_cfg_pkg::*; #(
  parameter int N_LANES = n_lanes_def,
  parameter int DATA_W = data_w_def,
  parameter int FIFO_DEPTH = fifo_depth_def
) (
  input  wire                       clk,
  input  wire                       rst,
  input  wire                       clear,
  input  wire [N_LANES-1:0]         push,
  input  wire [N_LANES*DATA_W-1:0]  push_data_flat,
  input  wire [N_LANES-1:0]         pop,
  output logic [N_LANES*DATA_W-1:0] out_data_flat,
  output logic [N_LANES-1:0]        out_nonempty,
  output logic [N_LANES-1:0]        out_room
);

  localparam int ptr_w = $clog2(FIFO_DEPTH);
  localparam int cnt_w = $clog2(FIFO_DEPTH + 1);

  for (genvar l = 0; l < N_LANES; l++) begin : g_lane
    logic [DATA_W-1:0] mem [FIFO_DEPTH];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;
    logic do_push;
    logic do_pop;

    assign do_push = push[l] && count != cnt_w'(FIFO_DEPTH);
    assign do_pop = pop[l] && out_nonempty[l];
    assign out_nonempty[l] = count != '0;
    // two free slots, one for the word still sitting in the pe register
    assign out_room[l] = count <= cnt_w'(FIFO_DEPTH - 2);
    assign out_data_flat[l*DATA_W +: DATA_W] = mem[rd_ptr];

    always_ff @(posedge clk) begin
      if (rst || clear) begin
        wr_ptr <= '0;
        rd_ptr <= '0;
        count <= '0;
      end else begin
        if (do_push) wr_ptr <= (wr_ptr == ptr_w'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
        if (do_pop) rd_ptr <= (rd_ptr == ptr_w'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
        count <= count + cnt_w'(do_push) - cnt_w'(do_pop);
      end
    end

    always_ff @(posedge clk) begin
      if (do_push) mem[wr_ptr] <= push_data_flat[l*DATA_W +: DATA_W];
    end
  end

endmodule

`default_nettype wire

//--- common/cgra_cfg_pkg.sv
`default_nettype none

package cgra_cfg_pkg;

  // defaults, cgra_top overrides through its own parameters
  localparam int n_lanes_def = 4;
  localparam int data_w_def = 16;
  localparam int fifo_depth_def = 8;

  // stream length and per-lane word counters
  localparam int len_w = 8;

  // lane operations, all wrap at the data width
  typedef enum logic [1:0] {
    op_pass = 2'd0,  // out = in
    op_add  = 2'd1,  // out = in + const
    op_sub  = 2'd2,  // out = in - const
    op_xor  = 2'd3   // out = in ^ const
  } pe_op_t;

endpackage

`default_nettype wire

//--- common/cgra_ctrl_pkg.sv
`default_nettype none

package cgra_ctrl_pkg;

  typedef enum logic [1:0] {
    st_idle      = 2'd0,
    st_wait_data = 2'd1,
    st_process   = 2'd2,
    st_done      = 2'd3
  } exec_state_t;

  // word addresses on the wishbone slave
  localparam int wb_adr_w = 4;
  localparam logic [wb_adr_w-1:0] reg_ctrl = 4'd0;
  localparam logic [wb_adr_w-1:0] reg_status = 4'd1;
  localparam logic [wb_adr_w-1:0] reg_mask = 4'd2;
  localparam logic [wb_adr_w-1:0] reg_length = 4'd3;
  localparam logic [wb_adr_w-1:0] reg_lane_cfg_base = 4'd4;  // one word per lane
  localparam logic [wb_adr_w-1:0] reg_queue_base = 4'd8;     // push in / pop out

  // bit positions inside ctrl and status
  localparam int ctrl_start_bit = 0;
  localparam int ctrl_clear_bit = 1;
  localparam int stat_state_lsb = 1;
  localparam int stat_nonempty_lsb = 8;
  localparam int stat_full_lsb = 12;

endpackage

`default_nettype wire

//--- hw/cgra_top.sv
`timescale 1ns/1ps
`default_nettype none

module cgra_top import cgra_cfg_pkg::*; import cgra_ctrl_pkg::*; #(
  parameter int N_LANES = n_lanes_def,  // at most 4, status layout
  parameter int DATA_W = data_w_def,
  parameter int FIFO_DEPTH = fifo_depth_def
) (
  input  wire                clk,
  input  wire                rst,
  input  wire                wb_cyc,
  input  wire                wb_stb,
  input  wire                wb_we,
  input  wire [wb_adr_w-1:0] wb_adr,
  input  wire [DATA_W-1:0]   wb_dat_w,
  output logic [DATA_W-1:0]  wb_dat_r,
  output logic               wb_ack
);

  logic start_pulse;
  logic clear_pulse;
  logic [N_LANES-1:0] lane_mask;
  logic [len_w-1:0] length;
  logic [2*N_LANES-1:0] op_flat;
  logic [N_LANES*DATA_W-1:0] const_flat;
  logic [N_LANES-1:0] push;
  logic [DATA_W-1:0] push_data;
  logic [N_LANES-1:0] pop;
  logic [N_LANES-1:0] in_valid;
  logic [N_LANES*DATA_W-1:0] in_data_flat;
  logic [N_LANES-1:0] in_full;
  logic [N_LANES-1:0] en;
  logic [N_LANES-1:0] pe_push;
  logic [N_LANES*DATA_W-1:0] pe_data_flat;
  logic [N_LANES-1:0] lane_done;
  logic [N_LANES*DATA_W-1:0] out_data_flat;
  logic [N_LANES-1:0] out_nonempty;
  logic [N_LANES-1:0] out_room;
  exec_state_t state;
  wire lane_done_all = &(lane_done | ~lane_mask);

  cgra_wb_regs #(.N_LANES(N_LANES), .DATA_W(DATA_W)) u_regs (
    .clk, .rst, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_dat_r, .wb_ack,
    .state, .lane_done_all, .in_full, .out_nonempty, .out_data_flat,
    .start_pulse, .clear_pulse, .lane_mask, .length, .op_flat, .const_flat,
    .push, .push_data, .pop
  );

  // input words survive a clear so a lane can be rerun with its mask set
  cgra_stream_in #(.N_LANES(N_LANES), .DATA_W(DATA_W), .FIFO_DEPTH(FIFO_DEPTH)) u_in (
    .clk, .rst, .clear(1'b0), .push, .push_data, .pop(en), .in_valid, .in_data_flat, .in_full
  );

  for (genvar i = 0; i < N_LANES; i++) begin : g_pe
    cgra_pe #(.DATA_W(DATA_W)) u_pe (
      .clk, .rst, .clear(clear_pulse), .en(en[i]),
      .op(pe_op_t'(op_flat[2*i +: 2])),
      .lane_const(const_flat[i*DATA_W +: DATA_W]),
      .length,
      .in_data(in_data_flat[i*DATA_W +: DATA_W]),
      .out_push(pe_push[i]),
      .out_data(pe_data_flat[i*DATA_W +: DATA_W]),
      .lane_done(lane_done[i])
    );
  end

  cgra_stream_out #(.N_LANES(N_LANES), .DATA_W(DATA_W), .FIFO_DEPTH(FIFO_DEPTH)) u_out (
    .clk, .rst, .clear(clear_pulse), .push(pe_push), .push_data_flat(pe_data_flat),
    .pop, .out_data_flat, .out_nonempty, .out_room
  );

  cgra_control_exec #(.N_LANES(N_LANES)) u_ctrl (
    .clk, .rst, .start(start_pulse), .clear(clear_pulse), .lane_mask,
    .in_valid, .out_room, .lane_done, .en, .state
  );

endmodule

`default_nettype wire

//--- hw/cgra_wb_regs.sv
`timescale 1ns/1ps
`default_nettype none

module cgra_wb_regs import cgra_cfg_pkg::*; import cgra_ctrl_pkg::*; #(
  parameter int N_LANES = n_lanes_def,
  parameter int DATA_W = data_w_def
) (
  input  wire                       clk,
  input  wire                       rst,
  input  wire                       wb_cyc,
  input  wire                       wb_stb,
  input  wire                       wb_we,
  input  wire [wb_adr_w-1:0]        wb_adr,
  input  wire [DATA_W-1:0]          wb_dat_w,
  output logic [DATA_W-1:0]         wb_dat_r,
  output logic                      wb_ack,
  input  wire exec_state_t          state,
  input  wire                       lane_done_all,
  input  wire [N_LANES-1:0]         in_full,
  input  wire [N_LANES-1:0]         out_nonempty,
  input  wire [N_LANES*DATA_W-1:0]  out_data_flat,
  output logic                      start_pulse,
  output logic                      clear_pulse,
  output logic [N_LANES-1:0]        lane_mask,
  output logic [len_w-1:0]          length,
  output logic [2*N_LANES-1:0]      op_flat,
  output logic [N_LANES*DATA_W-1:0] const_flat,
  output logic [N_LANES-1:0]        push,
  output logic [DATA_W-1:0]         push_data,
  output logic [N_LANES-1:0]        pop
);

  logic req;
  logic cfg_hit;
  logic queue_hit;
  logic [1:0] lane;
  logic done;
  logic [15:0] status;
  logic [DATA_W-1:0] rd_word;

  assign req = wb_cyc && wb_stb && !wb_ack;  // first cycle of a request only
  assign lane = wb_adr[1:0];  // both lane windows are 4-aligned
  assign cfg_hit = wb_adr >= reg_lane_cfg_base && wb_adr < reg_lane_cfg_base + N_LANES;
  assign queue_hit = wb_adr >= reg_queue_base && wb_adr < reg_queue_base + N_LANES;

  always_comb begin
    status = '0;
    status[0] = done;
    status[stat_state_lsb +: 2] = state;
    status[stat_nonempty_lsb +: N_LANES] = out_nonempty;
    status[stat_full_lsb +: N_LANES] = in_full;
  end

  always_comb begin
    rd_word = '0;
    if (cfg_hit) begin
      rd_word[9:0] = {op_flat[lane*2 +: 2], const_flat[lane*DATA_W +: 8]};
    end else if (queue_hit) begin
      if (out_nonempty[lane]) rd_word = out_data_flat[lane*DATA_W +: DATA_W];  // empty reads 0
    end else begin
      case (wb_adr)
        reg_status: rd_word[15:0] = status;
        reg_mask:   rd_word[N_LANES-1:0] = lane_mask;
        reg_length: rd_word[len_w-1:0] = length;
        default:    rd_word = '0;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wb_ack <= 1'b0;
      start_pulse <= 1'b0;
      clear_pulse <= 1'b0;
      push <= '0;
      pop <= '0;
      lane_mask <= '0;
      length <= '0;
      op_flat <= '0;
      const_flat <= '0;
      done <= 1'b0;
    end else begin
      wb_ack <= req;
      start_pulse <= req && wb_we && wb_adr == reg_ctrl && wb_dat_w[ctrl_start_bit];
      clear_pulse <= req && wb_we && wb_adr == reg_ctrl && wb_dat_w[ctrl_clear_bit];
      push <= '0;
      pop <= '0;
      if (req && queue_hit) begin
        if (wb_we) push[lane] <= !in_full[lane];  // full queue drops the word
        else pop[lane] <= out_nonempty[lane];
      end
      if (req && wb_we) begin
        if (wb_adr == reg_mask) lane_mask <= wb_dat_w[N_LANES-1:0];
        if (wb_adr == reg_length) length <= wb_dat_w[len_w-1:0];
        if (cfg_hit) begin
          op_flat[lane*2 +: 2] <= wb_dat_w[9:8];
          const_flat[lane*DATA_W +: DATA_W] <= DATA_W'(wb_dat_w[7:0]);
        end
      end
      if (clear_pulse) done <= 1'b0;
      else if (state == st_done && lane_done_all) done <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (req) wb_dat_r <= rd_word;  // valid alongside ack
    if (req && wb_we) push_data <= wb_dat_w;
  end

endmodule

`default_nettype wire

//--- project.f
common/cgra_cfg_pkg.sv
common/cgra_ctrl_pkg.sv
hw/cgra_wb_regs.sv
cgra/cgra_stream_in.sv
cgra/cgra_pe.sv
cgra/cgra_stream_out.sv
cgra/cgra_control_exec.sv
hw/cgra_top.sv
verification/cgra_props.sv
verification/cgra_tb.sv

//--- verification/cgra_props.sv
`timescale 1ns/1ps
`default_nettype none

module cgra_props import cgra_ctrl_pkg::*; #(
  parameter int N_LANES = 4
) (
  input wire               clk,
  input wire               rst,
  input wire               wb_ack,
  input wire               done,
  input wire exec_state_t  state,
  input wire [N_LANES-1:0] lane_mask,
  input wire [N_LANES-1:0] lane_done,
  input wire [N_LANES-1:0] out_room,
  input wire [N_LANES-1:0] en
);

  logic [N_LANES-1:0] active;

  assign active = lane_mask & ~lane_done;

  ack_one_cycle: assert property (@(posedge clk) disable iff (rst) wb_ack |=> !wb_ack)
    else $error("wishbone ack high for two cycles");

  en_only_in_process: assert property (
    @(posedge clk) disable iff (rst) state != st_process |-> en == '0)
    else $error("lane enable outside st_process");

  // lockstep rule, no lane fires into a full output queue
  en_needs_room: assert property (
    @(posedge clk) disable iff (rst) en != '0 |-> &(~active | out_room))
    else $error("lane enable while an active lane has no output room");

  done_in_done_state: assert property (@(posedge clk) disable iff (rst) done |-> state == st_done)
    else $error("done flag outside st_done");

endmodule

bind cgra_control_exec cgra_props #(.N_LANES(N_LANES)) u_props_exec (
  .clk, .rst, .wb_ack(1'b0), .done(1'b0), .state, .lane_mask, .lane_done, .out_room, .en
);

bind cgra_wb_regs cgra_props #(.N_LANES(N_LANES)) u_props_regs (
  .clk, .rst, .wb_ack, .done, .state, .lane_mask,
  .lane_done({N_LANES{1'b1}}), .out_room({N_LANES{1'b1}}), .en({N_LANES{1'b0}})
);

`default_nettype wire

//--- verification/cgra_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cgra_tb import cgra_cfg_pkg::*; import cgra_ctrl_pkg::*; ();

  localparam int n_lanes = n_lanes_def;
  localparam int data_w = data_w_def;
  localparam int depth = fifo_depth_def;
  localparam int ack_limit = 20;
  localparam int poll_limit = 400;
  localparam int stream_limit = 3000;

  logic clk;
  logic rst;
  logic wb_cyc;
  logic wb_stb;
  logic wb_we;
  logic [wb_adr_w-1:0] wb_adr;
  logic [data_w-1:0] wb_dat_w;
  logic [data_w-1:0] wb_dat_r;
  logic wb_ack;

  logic [15:0] lfsr;
  logic [data_w-1:0] words [n_lanes][16];  // queued inputs per lane in push order
  logic [1:0] lane_op [n_lanes];
  logic [7:0] lane_c [n_lanes];
  int checks;
  int errors;
  int tests_run;
  int tests_failed;
  int errors_at_start;

  cgra_top #(.N_LANES(n_lanes), .DATA_W(data_w), .FIFO_DEPTH(depth)) u_dut (
    .clk, .rst, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_dat_r, .wb_ack
  );

  always #50 clk = ~clk;

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic rand_bits(input int n, output logic [data_w-1:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      val = {val[data_w-2:0], lfsr[0]};
    end
  endtask

  // lane op rules wrap at the data width
  function automatic logic [data_w-1:0] model_op(input logic [1:0] op,
                                                 input logic [data_w-1:0] x,
                                                 input logic [7:0] c);
    case (op)
      op_add:  return x + data_w'(c);
      op_sub:  return x - data_w'(c);
      op_xor:  return x ^ data_w'(c);
      default: return x;
    endcase
  endfunction

  task automatic check_eq(input string name, input logic [data_w-1:0] got,
                          input logic [data_w-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %s got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  task automatic finish_run();
    $display("tests run %0d, tests failed %0d, checks %0d, mismatches %0d",
             tests_run, tests_failed, checks, errors);
    if (errors == 0 && tests_failed == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  endtask

  task automatic abort_run(input string why);
    $display("timeout: %s", why);
    errors++;
    tests_failed++;
    finish_run();
  endtask

  // entered and left 5 ns after a rising edge
  task automatic wb_xfer(input logic we, input logic [wb_adr_w-1:0] adr,
                         input logic [data_w-1:0] wdata, output logic [data_w-1:0] rdata);
    int n;
    n = 0;
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we = we;
    wb_adr = adr;
    wb_dat_w = wdata;
    @(posedge clk);
    #5;
    while (!wb_ack && n < ack_limit) begin
      @(posedge clk);
      #5;
      n++;
    end
    if (!wb_ack) abort_run($sformatf("no wishbone ack for address %0d", adr));
    rdata = wb_dat_r;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we = 1'b0;
  endtask

  task automatic wb_write(input logic [wb_adr_w-1:0] adr, input logic [data_w-1:0] wdata);
    logic [data_w-1:0] unused;
    wb_xfer(1'b1, adr, wdata, unused);
  endtask

  task automatic wb_read(input logic [wb_adr_w-1:0] adr, output logic [data_w-1:0] rdata);
    wb_xfer(1'b0, adr, '0, rdata);
  endtask

  task automatic wait_done();
    logic [data_w-1:0] st;
    int n;
    n = 0;
    wb_read(reg_status, st);
    while (!st[0] && n < poll_limit) begin
      wb_read(reg_status, st);
      n++;
    end
    if (!st[0]) abort_run("the run never reported done");
  endtask

  task automatic start_run();
    wb_write(reg_ctrl, data_w'(1 << ctrl_start_bit));
  endtask

  task automatic clear_run();
    wb_write(reg_ctrl, data_w'(1 << ctrl_clear_bit));
  endtask

  task automatic set_lane(input int l, input logic [1:0] op, input logic [7:0] c);
    lane_op[l] = op;
    lane_c[l] = c;
    wb_write(wb_adr_w'(reg_lane_cfg_base + l), data_w'({op, c}));
  endtask

  task automatic random_lanes();
    logic [data_w-1:0] op;
    logic [data_w-1:0] c;
    for (int l = 0; l < n_lanes; l++) begin
      rand_bits(2, op);
      rand_bits(8, c);
      set_lane(l, op[1:0], c[7:0]);
    end
  endtask

  task automatic fill_lane(input int l, input int n);
    for (int i = 0; i < n; i++) rand_bits(data_w, words[l][i]);
  endtask

  task automatic push_word(input int l, input int i);
    wb_write(wb_adr_w'(reg_queue_base + l), words[l][i]);
  endtask

  task automatic drain_lane(input int l, input int n);
    logic [data_w-1:0] got;
    for (int i = 0; i < n; i++) begin
      wb_read(wb_adr_w'(reg_queue_base + l), got);
      check_eq($sformatf("wb_dat_r lane %0d word %0d", l, i), got,
               model_op(lane_op[l], words[l][i], lane_c[l]));
    end
  endtask

  task automatic check_drained();
    logic [data_w-1:0] st;
    wb_read(reg_status, st);
    check_eq("status out_nonempty", st[stat_nonempty_lsb +: n_lanes], '0);
  endtask

  task automatic begin_test();
    tests_run++;
    errors_at_start = errors;
  endtask

  task automatic end_test(input string name);
    if (errors == errors_at_start) begin
      $display("test %0d %s: ok", tests_run, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: failed, %0d mismatches", tests_run, name,
               errors - errors_at_start);
    end
  endtask

  task automatic test_readback();
    logic [data_w-1:0] v;
    logic [data_w-1:0] got;
    begin_test();
    rand_bits(n_lanes, v);
    wb_write(reg_mask, v);
    wb_read(reg_mask, got);
    check_eq("wb_dat_r mask", got, v);
    rand_bits(len_w, v);
    wb_write(reg_length, v);
    wb_read(reg_length, got);
    check_eq("wb_dat_r length", got, v);
    random_lanes();
    for (int l = 0; l < n_lanes; l++) begin
      wb_read(wb_adr_w'(reg_lane_cfg_base + l), got);
      check_eq($sformatf("wb_dat_r lane %0d cfg", l), got, data_w'({lane_op[l], lane_c[l]}));
    end
    wb_read(reg_status, got);
    check_eq("status done", got[0], 1'b0);
    check_eq("status state", got[stat_state_lsb +: 2], st_idle);
    end_test("register readback");
  endtask

  task automatic test_single_lane();
    logic [data_w-1:0] c;
    begin_test();
    wb_write(reg_mask, data_w'(1));
    wb_write(reg_length, data_w'(8));
    rand_bits(8, c);
    set_lane(0, op_add, c[7:0]);
    fill_lane(0, 8);
    for (int i = 0; i < 8; i++) push_word(0, i);
    start_run();
    wait_done();
    drain_lane(0, 8);
    check_drained();
    end_test("single lane add");
  endtask

  task automatic test_all_lanes();
    begin_test();
    clear_run();
    wb_write(reg_mask, data_w'(4'hf));
    wb_write(reg_length, data_w'(8));
    random_lanes();
    for (int l = 0; l < n_lanes; l++) begin
      fill_lane(l, 8);
      for (int i = 0; i < 8; i++) push_word(l, i);
    end
    start_run();
    wait_done();
    for (int l = 0; l < n_lanes; l++) drain_lane(l, 8);
    check_drained();
    end_test("all lanes");
  endtask

  task automatic test_masked_lane();
    logic [data_w-1:0] st;
    begin_test();
    clear_run();
    wb_write(reg_mask, data_w'(4'b1011));  // lane 2 left out
    wb_write(reg_length, data_w'(8));
    random_lanes();
    for (int l = 0; l < n_lanes; l++) begin
      fill_lane(l, 8);
      for (int i = 0; i < 8; i++) push_word(l, i);
    end
    start_run();
    wait_done();
    wb_read(reg_status, st);
    check_eq("status out_nonempty lane 2", st[stat_nonempty_lsb + 2], 1'b0);
    check_eq("status in_full lane 2", st[stat_full_lsb + 2], 1'b1);  // all 8 words kept
    drain_lane(0, 8);
    drain_lane(1, 8);
    drain_lane(3, 8);
    // rerun with only lane 2 on and its queued words still waiting
    clear_run();
    wb_write(reg_mask, data_w'(4'b0100));
    start_run();
    wait_done();
    drain_lane(2, 8);
    check_drained();
    end_test("masked-out lane");
  endtask

  task automatic test_backpressure();
    logic [data_w-1:0] st;
    logic [data_w-1:0] got;
    int pushed [n_lanes];
    int popped [n_lanes];
    int n;
    int total;
    begin_test();
    clear_run();
    wb_write(reg_mask, data_w'(4'hf));
    wb_write(reg_length, data_w'(12));
    random_lanes();
    for (int l = 0; l < n_lanes; l++) begin
      fill_lane(l, 12);
      // full input queues back the output queues up before the host drains
      for (int i = 0; i < depth; i++) push_word(l, i);
      pushed[l] = depth;
      popped[l] = 0;
    end
    start_run();
    n = 0;
    total = 0;
    while (total < 12 * n_lanes && n < stream_limit) begin
      wb_read(reg_status, st);  // only the host fills in or empties out
      for (int l = 0; l < n_lanes; l++) begin
        if (pushed[l] < 12 && !st[stat_full_lsb + l]) begin
          push_word(l, pushed[l]);
          pushed[l]++;
        end
        if (popped[l] < 12 && st[stat_nonempty_lsb + l]) begin
          wb_read(wb_adr_w'(reg_queue_base + l), got);
          check_eq($sformatf("wb_dat_r lane %0d word %0d", l, popped[l]), got,
                   model_op(lane_op[l], words[l][popped[l]], lane_c[l]));
          popped[l]++;
          total++;
        end
      end
      n++;
    end
    if (total < 12 * n_lanes) abort_run("results still missing in the streaming run");
    wait_done();
    check_drained();
    end_test("back-pressure and late data");
  endtask

  task automatic test_clear();
    logic [data_w-1:0] st;
    logic [data_w-1:0] c;
    begin_test();
    clear_run();
    wb_read(reg_status, st);
    check_eq("status done", st[0], 1'b0);
    check_eq("status state", st[stat_state_lsb +: 2], st_idle);
    wb_write(reg_mask, data_w'(4'b0010));
    wb_write(reg_length, data_w'(4));
    rand_bits(8, c);
    set_lane(1, op_sub, c[7:0]);
    fill_lane(1, 4);
    for (int i = 0; i < 4; i++) push_word(1, i);
    start_run();
    wait_done();
    wb_read(reg_status, st);
    check_eq("status state", st[stat_state_lsb +: 2], st_done);
    drain_lane(1, 4);
    check_drained();
    end_test("clear and rerun");
  endtask

  initial begin
    clk = 1'b0;
    rst = 1'b1;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we = 1'b0;
    wb_adr = '0;
    wb_dat_w = '0;
    lfsr = 16'd35;
    checks = 0;
    errors = 0;
    tests_run = 0;
    tests_failed = 0;
    errors_at_start = 0;
    repeat (5) @(posedge clk);
    #5;
    rst = 1'b0;
    test_readback();
    test_single_lane();
    test_all_lanes();
    test_masked_lane();
    test_backpressure();
    test_clear();
    finish_run();
  end

endmodule

`default_nettype wire
